//--- src/fetch_types_pkg.sv
package fetch_types_pkg;

  // ======================================================================
  // widths
  // ======================================================================
  localparam int ADDR_W        = 32;
  localparam int LINE_W        = 128;
  localparam int INST_W        = 32;
  // byte offset inside one 16-byte line
  localparam int LINE_OFFSET_W = 4;

  typedef logic [ADDR_W-1:0]               addr_t;
  typedef logic [ADDR_W-LINE_OFFSET_W-1:0] line_tag_t;
  typedef logic [LINE_W-1:0]               line_data_t;
  typedef logic [INST_W-1:0]               inst_t;

  // ======================================================================
  // queue geometry
  // ======================================================================
  localparam int QUEUE_DEPTH = 2;
  // one wrap bit plus one index bit
  localparam int PTR_W       = 2;

  localparam addr_t     RESET_PC  = 32'h8000_0000;
  localparam line_tag_t RESET_TAG = RESET_PC[ADDR_W-1:LINE_OFFSET_W];

endpackage

//--- src/line_bus_pkg.sv
package line_bus_pkg;

  // anything but okay marks the line faulty
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // ======================================================================
  // read channel sequencing
  // ======================================================================
  typedef enum logic [1:0] {
    // waiting for queue space
    FETCH_IDLE,
    // address presented, waiting for ar_ready
    FETCH_ADDR,
    // waiting for the line
    FETCH_DATA
  } fetch_state_e;

endpackage

//--- src/line_fetch_fsm.sv
module line_fetch_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       space_i,
  input  fetch_types_pkg::line_tag_t fetch_tag_i,
  input  logic                       redirect_i,
  input  logic                       ar_ready_i,
  input  logic                       r_valid_i,
  input  line_bus_pkg::resp_t        r_resp_i,
  output logic                       ar_valid_o,
  output fetch_types_pkg::addr_t     ar_addr_o,
  output logic                       r_ready_o,
  output logic                       push_o,
  output logic                       push_err_o
);

  import fetch_types_pkg::*;
  import line_bus_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  line_tag_t    req_tag_q;
  logic         drop_q;
  logic         r_done;

  assign r_done = r_valid_i & r_ready_o;

  // ======================================================================
  // state register
  // ======================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (space_i && !redirect_i) begin
          state_d = FETCH_ADDR;
        end
      end
      FETCH_ADDR: begin
        if (ar_ready_i) begin
          state_d = FETCH_DATA;
        end
      end
      FETCH_DATA: begin
        if (r_valid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request line is the prefetch tag at the moment the request starts
  always_ff @(posedge clk) begin
    if (state_q == FETCH_IDLE && state_d == FETCH_ADDR) begin
      req_tag_q <= fetch_tag_i;
    end
  end

  // a read flushed mid-flight still finishes on the bus but is not stored
  always_ff @(posedge clk) begin
    if (rst_n) begin
      drop_q <= 1'b0;
    end else if (r_done) begin
      drop_q <= 1'b0;
    end else if (redirect_i && state_q != FETCH_IDLE) begin
      drop_q <= 1'b1;
    end
  end

  assign ar_valid_o = (state_q == FETCH_ADDR);
  assign ar_addr_o  = {req_tag_q, {LINE_OFFSET_W{1'b0}}};
  assign r_ready_o  = (state_q == FETCH_DATA);

  // a redirect on the same edge also makes the arriving line stale
  assign push_o     = r_done & ~drop_q & ~redirect_i;
  assign push_err_o = (r_resp_i != RESP_OKAY);

endmodule

//--- src/line_queue_ptrs.sv
module line_queue_ptrs (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                push_i,
  input  logic                                advance_i,
  input  logic                                redirect_i,
  input  fetch_types_pkg::line_tag_t          redirect_tag_i,
  output logic                                waddr_o,
  output logic                                raddr_o,
  output fetch_types_pkg::line_tag_t          head_tag_o,
  output fetch_types_pkg::line_tag_t          fetch_tag_o,
  output logic [fetch_types_pkg::PTR_W-1:0]   count_o,
  output logic                                space_o
);

  import fetch_types_pkg::*;

  logic [PTR_W-1:0] wptr_q;
  logic [PTR_W-1:0] rptr_q;
  line_tag_t        head_tag_q;

  // ======================================================================
  // wrap pointers
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wptr_q <= '0;
    end else if (push_i) begin
      wptr_q <= wptr_q + 1'b1;
    end
  end

  // redirect re-bases the queue so it reads as empty
  always_ff @(posedge clk) begin
    if (rst_n) begin
      rptr_q <= '0;
    end else if (redirect_i) begin
      rptr_q <= wptr_q;
    end else if (advance_i) begin
      rptr_q <= rptr_q + 1'b1;
    end
  end

  // line number of the queue head
  always_ff @(posedge clk) begin
    if (rst_n) begin
      head_tag_q <= RESET_TAG;
    end else if (redirect_i) begin
      head_tag_q <= redirect_tag_i;
    end else if (advance_i) begin
      head_tag_q <= head_tag_q + 1'b1;
    end
  end

  // occupancy is the pointer distance so push plus advance cancels out
  assign count_o     = wptr_q - rptr_q;
  assign space_o     = (count_o < QUEUE_DEPTH);
  assign fetch_tag_o = head_tag_q + line_tag_t'(count_o);
  assign head_tag_o  = head_tag_q;
  assign waddr_o     = wptr_q[0];
  assign raddr_o     = rptr_q[0];

endmodule

//--- src/line_store.sv
module line_store (
  input  logic                        clk,
  input  logic                        we_i,
  input  logic                        waddr_i,
  input  logic                        raddr_i,
  input  fetch_types_pkg::line_data_t wdata_i,
  input  logic                        werr_i,
  output fetch_types_pkg::line_data_t rdata_o,
  output logic                        rerr_o
);

  import fetch_types_pkg::*;

  line_data_t mem_q [QUEUE_DEPTH];
  logic       err_q [QUEUE_DEPTH];

  // ======================================================================
  // line registers
  // ======================================================================
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
      err_q[waddr_i] <= werr_i;
    end
  end

  // a written line shows one cycle later
  assign rdata_o = mem_q[raddr_i];
  assign rerr_o  = err_q[raddr_i];

endmodule

//--- src/inst_select.sv
module inst_select (
  input  fetch_types_pkg::addr_t              pc_i,
  input  logic                                flush_i,
  input  fetch_types_pkg::line_tag_t          head_tag_i,
  input  logic [fetch_types_pkg::PTR_W-1:0]   count_i,
  input  fetch_types_pkg::line_data_t         line_i,
  input  logic                                line_err_i,
  output logic                                inst_valid_o,
  output logic                                inst_err_o,
  output fetch_types_pkg::inst_t              inst_o,
  output logic                                advance_o,
  output logic                                redirect_o
);

  import fetch_types_pkg::*;

  line_tag_t pc_tag;
  line_tag_t next_tag;
  logic      hit;
  logic      not_empty;
  inst_t     word;

  assign pc_tag    = pc_i[ADDR_W-1:LINE_OFFSET_W];
  assign next_tag  = head_tag_i + 1'b1;
  assign hit       = (pc_tag == head_tag_i);
  assign not_empty = (count_i != '0);

  // pc stepped into the next queued line
  assign advance_o    = (pc_tag == next_tag) & not_empty & ~flush_i;
  assign redirect_o   = flush_i & ~hit;
  assign inst_valid_o = hit & not_empty & ~flush_i;

  // word index from pc[3:2]
  assign word = line_i[{pc_i[LINE_OFFSET_W-1:2], 5'b0} +: INST_W];

  assign inst_o     = inst_valid_o ? word : '0;
  assign inst_err_o = inst_valid_o & line_err_i;

endmodule

//--- src/fetch_buffer.sv
module fetch_buffer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  fetch_types_pkg::addr_t      pc_i,
  input  logic                        flush_i,
  output logic                        inst_valid_o,
  output fetch_types_pkg::inst_t      inst_o,
  output logic                        inst_err_o,
  input  logic                        ar_ready_i,
  output logic                        ar_valid_o,
  output fetch_types_pkg::addr_t      ar_addr_o,
  input  logic                        r_valid_i,
  input  fetch_types_pkg::line_data_t r_data_i,
  input  line_bus_pkg::resp_t         r_resp_i,
  output logic                        r_ready_o
);

  import fetch_types_pkg::*;

  logic             push;
  logic             push_err;
  logic             advance;
  logic             redirect;
  logic             space;
  logic             waddr;
  logic             raddr;
  line_tag_t        head_tag;
  line_tag_t        fetch_tag;
  logic [PTR_W-1:0] count;
  line_data_t       head_line;
  logic             head_err;

  // ======================================================================
  // read channel
  // ======================================================================
  line_fetch_fsm u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .space_i     (space),
    .fetch_tag_i (fetch_tag),
    .redirect_i  (redirect),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_valid_i),
    .r_resp_i    (r_resp_i),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .r_ready_o   (r_ready_o),
    .push_o      (push),
    .push_err_o  (push_err)
  );

  // ======================================================================
  // line queue
  // ======================================================================
  line_queue_ptrs u_ptrs (
    .clk            (clk),
    .rst_n          (rst_n),
    .push_i         (push),
    .advance_i      (advance),
    .redirect_i     (redirect),
    .redirect_tag_i (pc_i[ADDR_W-1:LINE_OFFSET_W]),
    .waddr_o        (waddr),
    .raddr_o        (raddr),
    .head_tag_o     (head_tag),
    .fetch_tag_o    (fetch_tag),
    .count_o        (count),
    .space_o        (space)
  );

  line_store u_store (
    .clk     (clk),
    .we_i    (push),
    .waddr_i (waddr),
    .raddr_i (raddr),
    .wdata_i (r_data_i),
    .werr_i  (push_err),
    .rdata_o (head_line),
    .rerr_o  (head_err)
  );

  // fetch side
  inst_select u_select (
    .pc_i         (pc_i),
    .flush_i      (flush_i),
    .head_tag_i   (head_tag),
    .count_i      (count),
    .line_i       (head_line),
    .line_err_i   (head_err),
    .inst_valid_o (inst_valid_o),
    .inst_err_o   (inst_err_o),
    .inst_o       (inst_o),
    .advance_o    (advance),
    .redirect_o   (redirect)
  );

endmodule

//--- bench/fetch_buffer_sva.sv
module fetch_buffer_sva (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   flush_i,
  input logic                   inst_valid_o,
  input logic                   ar_ready_i,
  input logic                   ar_valid_o,
  input fetch_types_pkg::addr_t ar_addr_o,
  input logic                   r_ready_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;

  // address phase holds until accepted
  ar_hold_a: assert property (@(posedge clk) disable iff (rst_n)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
  else begin
    $error("ar_valid_o or ar_addr_o changed while ar_ready_i was low");
    assert_fails++;
  end

  // one phase at a time on the read channel
  one_phase_a: assert property (@(posedge clk) disable iff (rst_n)
    !(ar_valid_o && r_ready_o))
  else begin
    $error("r_ready_o and ar_valid_o high in the same cycle");
    assert_fails++;
  end

  flush_quiet_a: assert property (@(posedge clk) disable iff (rst_n)
    flush_i |-> !inst_valid_o)
  else begin
    $error("inst_valid_o high during a flush");
    assert_fails++;
  end

endmodule

bind fetch_buffer fetch_buffer_sva u_sva (.*);

//--- bench/fetch_buffer_tb.sv
module fetch_buffer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_types_pkg::*;
  import line_bus_pkg::*;

  localparam int N_STEPS        = 400;
  localparam int SERVE_LIMIT    = 40;
  localparam int TIMEOUT_CYCLES = N_STEPS * SERVE_LIMIT;

  logic       clk;
  logic       rst_n;
  addr_t      pc_i;
  logic       flush_i;
  logic       inst_valid_o;
  inst_t      inst_o;
  logic       inst_err_o;
  logic       ar_ready_i;
  logic       ar_valid_o;
  addr_t      ar_addr_o;
  logic       r_valid_i;
  line_data_t r_data_i;
  resp_t      r_resp_i;
  logic       r_ready_o;

  logic [31:0] rng_state = 32'h45f7;
  int          errors [1:6] = '{default: 0};
  int          checks [1:6] = '{default: 0};
  int          cycles = 0;
  int          steps = 0;
  int          outstanding = 0;
  int          ar_wait = 0;
  int          r_wait = 0;
  int          idle_cycles = 0;
  logic        pending = 1'b0;
  logic        ar_seen = 1'b0;
  logic        first_req_done = 1'b0;
  logic        flush_armed = 1'b0;
  logic        post_flush = 1'b0;
  logic        flush_redirect = 1'b0;
  line_tag_t   flush_line;
  addr_t       pend_addr;
  // outputs as seen at the last falling edge
  logic        s_ar_valid;
  logic        s_r_ready;
  logic        s_inst_valid;
  addr_t       s_ar_addr;

  fetch_buffer u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_below(input int n);
    return int'(rand_next() >> 16) % n;
  endfunction

  // ======================================================================
  // memory image behind the cache
  // ======================================================================
  function automatic inst_t mem_word(input addr_t a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    return (w ^ (w >> 13)) * 32'h9e37_79b1 + 32'h6b43_a9b5;
  endfunction

  // word k of a line sits at byte offset 4k
  function automatic line_data_t line_image(input addr_t a);
    line_data_t l;
    for (int k = 0; k < 4; k++) begin
      l[32*k +: 32] = mem_word({a[31:4], 4'h0} + 32'(4 * k));
    end
    return l;
  endfunction

  function automatic logic line_faulty(input addr_t a);
    return ((32'(a[31:4]) % 7) == 3);
  endfunction

  task automatic report_mismatch(input int t, input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Mismatch at %0d ns: %s expected %h, got %h", $time, sig, exp, act);
    errors[t]++;
  endtask

  task automatic report_failure(input int t, input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    errors[t]++;
  endtask

  // ======================================================================
  // cache responder and pc stimulus on the rising edge
  // ======================================================================
  task automatic drive_inputs();
    addr_t jump;
    if (r_valid_i && s_r_ready) begin
      outstanding--;
      pending = 1'b0;
      r_valid_i <= 1'b0;
    end else if (pending && !r_valid_i) begin
      if (r_wait == 0) begin
        r_valid_i <= 1'b1;
        r_data_i  <= line_image(pend_addr);
        r_resp_i  <= line_faulty(pend_addr) ? 2'd2 : RESP_OKAY;
      end else begin
        r_wait--;
      end
    end
    if (s_ar_valid && ar_ready_i) begin
      outstanding++;
      checks[5]++;
      if (outstanding > 1) report_failure(5, "second read issued while one was outstanding");
      pending   = 1'b1;
      pend_addr = s_ar_addr;
      ar_seen   = 1'b0;
      r_wait    = rand_below(4);
      ar_wait   = rand_below(4);
      ar_ready_i <= 1'b0;
    end else if (s_ar_valid) begin
      if (ar_wait == 0) ar_ready_i <= 1'b1;
      else ar_wait--;
    end
    // the fetch stage only steps past an instruction it got
    if (flush_i) begin
      flush_i <= 1'b0;
    end else if (first_req_done && rand_below(32) == 0) begin
      jump = RESET_PC | (rand_next() & 32'h000f_fffc);
      flush_redirect = (jump[31:4] != pc_i[31:4]);
      flush_line = jump[31:4];
      pc_i    <= jump;
      flush_i <= 1'b1;
      steps++;
      checks[4]++;
      idle_cycles = 0;
    end else if (s_inst_valid && rand_below(2) == 1) begin
      pc_i <= pc_i + 32'd4;
      steps++;
      checks[4]++;
      idle_cycles = 0;
    end
  endtask

  // ======================================================================
  // sampling and checks on the falling edge
  // ======================================================================
  task automatic sample_and_check();
    s_ar_valid   = ar_valid_o;
    s_ar_addr    = ar_addr_o;
    s_r_ready    = r_ready_o;
    s_inst_valid = inst_valid_o;
    if (inst_valid_o) begin
      checks[2]++;
      if (inst_o !== mem_word(pc_i)) report_mismatch(2, "inst_o", mem_word(pc_i), inst_o);
      if (inst_err_o !== line_faulty(pc_i)) begin
        report_mismatch(2, "inst_err_o", line_faulty(pc_i), inst_err_o);
      end
      if (post_flush) begin
        checks[3]++;
        post_flush = 1'b0;
        if (inst_o !== mem_word(pc_i)) report_failure(3, "stale instruction served after flush");
      end
      idle_cycles = 0;
    end else begin
      // outputs read as zero while not valid
      if (inst_o !== '0) report_mismatch(2, "inst_o", 32'h0, inst_o);
      if (inst_err_o !== 1'b0) report_mismatch(2, "inst_err_o", 32'h0, inst_err_o);
      idle_cycles++;
      if (idle_cycles == SERVE_LIMIT) begin
        report_failure(4, $sformatf("pc %h not served within %0d cycles", pc_i, SERVE_LIMIT));
      end
    end
    // a request seen for the first time
    if (ar_valid_o && !ar_seen) begin
      ar_seen = 1'b1;
      checks[5]++;
      if (ar_addr_o[3:0] != 4'h0) report_failure(5, "read address is not line-aligned");
      if (!first_req_done) begin
        first_req_done = 1'b1;
        checks[1]++;
        if (ar_addr_o !== RESET_PC) report_mismatch(1, "ar_addr_o", RESET_PC, ar_addr_o);
        $display("test 1 reset and first request: %0d errors", errors[1]);
      end else if (!flush_i) begin
        if (ar_addr_o[31:4] > pc_i[31:4] + 1) begin
          report_failure(5, "prefetch ran more than one line ahead of the pc");
        end
        if (flush_armed) begin
          checks[3]++;
          flush_armed = 1'b0;
          if (ar_addr_o[31:4] !== flush_line) begin
            report_mismatch(3, "ar_addr_o", {flush_line, 4'h0}, ar_addr_o);
          end
        end
      end
    end
    if (flush_i && flush_redirect) begin
      flush_armed = 1'b1;
      post_flush  = 1'b1;
    end
  endtask

  initial begin : main
    int total;
    rst_n      = 1'b1;
    pc_i       = RESET_PC;
    flush_i    = 1'b0;
    ar_ready_i = 1'b0;
    r_valid_i  = 1'b0;
    r_data_i   = '0;
    r_resp_i   = RESP_OKAY;
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    checks[1]++;
    if (ar_valid_o !== 1'b0 || r_ready_o !== 1'b0 || inst_valid_o !== 1'b0) begin
      report_failure(1, "read channel or inst_valid_o active right after reset");
    end
    sample_and_check();
    while (steps < N_STEPS && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      sample_and_check();
      cycles++;
    end
    if (!first_req_done) begin
      report_failure(1, "no read request after reset");
      $display("test 1 reset and first request: %0d errors", errors[1]);
    end
    if (steps < N_STEPS) begin
      $display("Error: timeout after %0d cycles, %0d of %0d pc steps done",
               cycles, steps, N_STEPS);
      errors[4]++;
    end
    errors[6] = u_dut.u_sva.assert_fails;
    $display("test 2 instruction data: %0d checks, %0d errors", checks[2], errors[2]);
    $display("test 3 flush redirect: %0d checks, %0d errors", checks[3], errors[3]);
    $display("test 4 serve latency: %0d checks, %0d errors", checks[4], errors[4]);
    $display("test 5 read requests: %0d checks, %0d errors", checks[5], errors[5]);
    $display("test 6 bus protocol assertions: %0d errors", errors[6]);
    total = 0;
    for (int t = 1; t <= 6; t++) begin
      total += errors[t];
    end
    $display("summary: %0d cycles, %0d pc steps, %0d errors", cycles, steps, total);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
src/fetch_types_pkg.sv
src/line_bus_pkg.sv
src/line_fetch_fsm.sv
src/line_queue_ptrs.sv
src/line_store.sv
src/inst_select.sv
src/fetch_buffer.sv
bench/fetch_buffer_sva.sv
bench/fetch_buffer_tb.sv

//--- Bender.yml
package:
  name: fetch_buffer

sources:
  - src/fetch_types_pkg.sv
  - src/line_bus_pkg.sv
  - src/line_fetch_fsm.sv
  - src/line_queue_ptrs.sv
  - src/line_store.sv
  - src/inst_select.sv
  - src/fetch_buffer.sv
  - target: test
    files:
      - bench/fetch_buffer_sva.sv
      - bench/fetch_buffer_tb.sv
